// ==== design/floor_pkg.sv ====
// Floor request controller shared definitions
// Floor count, floor number and lamp mask types, dispatch FSM states

package floor_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Building geometry
    ////////////////////////////////////////////////////////////////////////////

    // Number of served floors
    localparam int NUM_FLOORS = 11;

    // Bits needed to encode a floor number
    localparam int FLOOR_W = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Floor number, 0 to NUM_FLOORS-1
    typedef logic [FLOOR_W-1:0] floor_t;

    // One bit per floor, for buttons and lamps
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Car dispatch handshake FSM
    // IDLE     waiting for a pending request
    // REQUEST  move_req high, waiting for the car to arrive
    // RELEASE  move_req low, waiting for move_ack to fall
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        REQUEST = 2'd1,
        RELEASE = 2'd2
    } dispatch_state_t;

endpackage

// ==== design/button_capture.sv ====
// Button capture
// Picks at most one accepted press per cycle, panel first and lowest floor first,
// pushes it to the request stack and keeps the panel and call lamps

module button_capture (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   power_switch,
    input  logic                   emergency_btn,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   full,
    input  logic                   pop,
    input  floor_pkg::floor_t      served_floor,
    output logic                   push_valid,
    output floor_pkg::floor_t      push_floor,
    output floor_pkg::floor_mask_t panel_lights,
    output floor_pkg::floor_mask_t call_lights
);

    logic                   abort;
    floor_pkg::floor_mask_t lit;
    floor_pkg::floor_mask_t here_mask;
    floor_pkg::floor_mask_t panel_elig;
    floor_pkg::floor_mask_t call_elig;
    floor_pkg::floor_mask_t pick_mask;
    floor_pkg::floor_mask_t push_mask;
    floor_pkg::floor_mask_t clear_mask;
    logic                   take_panel;

    // Index of the lowest set bit, zero when the mask is empty
    function automatic floor_pkg::floor_t lowest_floor(input floor_pkg::floor_mask_t mask);
        floor_pkg::floor_t result;
        result = '0;
        for (int i = floor_pkg::NUM_FLOORS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                result = floor_pkg::floor_t'(i);
            end
        end
        return result;
    endfunction

    assign abort = !power_switch || emergency_btn;

    ////////////////////////////////////////////////////////////////////////////
    // Press selection
    ////////////////////////////////////////////////////////////////////////////

    // A floor with either lamp lit is already on the stack
    assign lit       = panel_lights | call_lights;
    assign here_mask = floor_pkg::floor_mask_t'(1) << current_floor;

    assign panel_elig = panel_buttons & ~lit & ~here_mask;
    assign call_elig  = floor_call_buttons & ~lit & ~here_mask;

    // Panel presses win over calls in the same cycle
    assign take_panel = |panel_elig;
    assign pick_mask  = take_panel ? panel_elig : call_elig;

    assign push_floor = lowest_floor(pick_mask);

    // A full stack drops the press, no lamp is lit for it
    assign push_valid = !abort && !full && (|pick_mask);

    assign push_mask  = push_valid ? (floor_pkg::floor_mask_t'(1) << push_floor) : '0;
    assign clear_mask = pop ? (floor_pkg::floor_mask_t'(1) << served_floor) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Lamps
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else if (abort) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else begin
            // Served floor goes dark on both panels, new request lights up
            panel_lights <= (panel_lights & ~clear_mask) | (take_panel ? push_mask : '0);
            call_lights  <= (call_lights & ~clear_mask) | (take_panel ? '0 : push_mask);
        end
    end

endmodule

// ==== design/request_stack.sv ====
// Floor request stack
// LIFO of pending floor numbers; push and pop take one edge, clear wins over both

module request_stack #(
    parameter int STACK_DEPTH = 11
) (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              power_switch,
    input  logic              emergency_btn,
    input  logic              push_valid,
    input  floor_pkg::floor_t push_floor,
    input  logic              pop,
    output floor_pkg::floor_t top_floor,
    output logic              empty,
    output logic              full
);

    // Count needs one value more than the number of slots
    localparam int PTR_W = $clog2(STACK_DEPTH + 1);
    localparam int IDX_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

    floor_pkg::floor_t entries [STACK_DEPTH];

    logic             abort;
    logic             do_push;
    logic             do_pop;
    logic [PTR_W-1:0] count;
    logic [PTR_W-1:0] count_next;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] top_ptr;

    assign abort = !power_switch || emergency_btn;

    assign do_push = push_valid && !full && !abort;
    assign do_pop  = pop && !empty && !abort;

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + PTR_W'(1);
        end else if (do_pop && !do_push) begin
            count_next = count - PTR_W'(1);
        end
    end

    // On a simultaneous pop the new entry overwrites the old top
    assign wr_ptr  = do_pop ? (count - PTR_W'(1)) : count;
    assign top_ptr = empty ? '0 : (count - PTR_W'(1));

    assign top_floor = entries[top_ptr[IDX_W-1:0]];

    ////////////////////////////////////////////////////////////////////////////
    // Pointer and flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
            empty <= 1'b1;
            full  <= 1'b0;
        end else if (abort) begin
            count <= '0;
            empty <= 1'b1;
            full  <= 1'b0;
        end else begin
            count <= count_next;
            empty <= (count_next == '0);
            full  <= (count_next == PTR_W'(STACK_DEPTH));
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr[IDX_W-1:0]] <= push_floor;
        end
    end

endmodule

// ==== design/dispatch_control.sv ====
// Car dispatch control
// Offers the floor on top of the stack to the car over a four-phase req/ack pair,
// pops the request when the car acknowledges arrival

module dispatch_control (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              power_switch,
    input  logic              emergency_btn,
    input  logic              empty,
    input  floor_pkg::floor_t top_floor,
    input  floor_pkg::floor_t current_floor,
    input  logic              move_ack,
    output logic              move_req,
    output floor_pkg::floor_t target_floor,
    output logic              direction_up,
    output logic              pop,
    output floor_pkg::floor_t served_floor
);

    floor_pkg::dispatch_state_t state;
    floor_pkg::dispatch_state_t state_next;

    logic abort;
    logic start;

    assign abort = !power_switch || emergency_btn;

    // New request only once the car has released the previous ack
    assign start = (state == floor_pkg::IDLE) && !abort && !empty && !move_ack;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            floor_pkg::IDLE: begin
                if (start) begin
                    state_next = floor_pkg::REQUEST;
                end
            end
            floor_pkg::REQUEST: begin
                // Abort withdraws the request even without an ack
                if (abort || move_ack) begin
                    state_next = floor_pkg::RELEASE;
                end
            end
            floor_pkg::RELEASE: begin
                if (!move_ack) begin
                    state_next = floor_pkg::IDLE;
                end
            end
            default: begin
                state_next = floor_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= floor_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Target and direction held for the whole request
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= '0;
            direction_up <= 1'b0;
        end else if (start) begin
            target_floor <= top_floor;
            direction_up <= (top_floor > current_floor);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    assign move_req = (state == floor_pkg::REQUEST);

    // One cycle wide, the cycle the arrival is seen
    assign pop          = (state == floor_pkg::REQUEST) && move_ack && !abort;
    assign served_floor = target_floor;

endmodule

// ==== design/floor_request_top.sv ====
// Elevator floor request controller
// Button capture feeds a LIFO of floor requests, dispatch control serves
// the top entry to the car over a req/ack handshake

module floor_request_top #(
    parameter int STACK_DEPTH = 11
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   power_switch,
    input  logic                   emergency_btn,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   move_ack,
    output logic                   move_req,
    output floor_pkg::floor_t      target_floor,
    output logic                   direction_up,
    output floor_pkg::floor_mask_t panel_lights,
    output floor_pkg::floor_mask_t call_lights
);

    // Capture to stack
    logic              push_valid;
    floor_pkg::floor_t push_floor;

    // Stack status
    logic              empty;
    logic              full;
    floor_pkg::floor_t top_floor;

    // Arrival from dispatch
    logic              pop;
    floor_pkg::floor_t served_floor;

    button_capture u_button_capture (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .panel_buttons      (panel_buttons),
        .floor_call_buttons (floor_call_buttons),
        .current_floor      (current_floor),
        .full               (full),
        .pop                (pop),
        .served_floor       (served_floor),
        .push_valid         (push_valid),
        .push_floor         (push_floor),
        .panel_lights       (panel_lights),
        .call_lights        (call_lights)
    );

    request_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) u_request_stack (
        .clock         (clock),
        .reset_n       (reset_n),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .push_valid    (push_valid),
        .push_floor    (push_floor),
        .pop           (pop),
        .top_floor     (top_floor),
        .empty         (empty),
        .full          (full)
    );

    dispatch_control u_dispatch_control (
        .clock         (clock),
        .reset_n       (reset_n),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .empty         (empty),
        .top_floor     (top_floor),
        .current_floor (current_floor),
        .move_ack      (move_ack),
        .move_req      (move_req),
        .target_floor  (target_floor),
        .direction_up  (direction_up),
        .pop           (pop),
        .served_floor  (served_floor)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
// Testbench clock source
// Free-running clock with a configurable period

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

endmodule

// ==== bench/floor_request_checker.sv ====
// Floor request handshake checker
// Concurrent assertions on the car req/ack pair and on lamp clearing

module floor_request_checker (
    input logic                   clock,
    input logic                   reset_n,
    input logic                   power_switch,
    input logic                   emergency_btn,
    input logic                   move_req,
    input logic                   move_ack,
    input floor_pkg::floor_t      target_floor,
    input floor_pkg::floor_mask_t panel_lights,
    input floor_pkg::floor_mask_t call_lights
);

    // Request is only withdrawn by an ack or an abort
    a_req_held: assert property (@(posedge clock) disable iff (!reset_n)
        (move_req && !move_ack && power_switch && !emergency_btn) |=> move_req)
        else $error("move_req fell before move_ack");

    a_target_stable: assert property (@(posedge clock) disable iff (!reset_n)
        move_req |=> (!move_req || $stable(target_floor)))
        else $error("target_floor changed while move_req was high");

    // Power off wipes every lamp in one edge
    a_lamps_clear: assert property (@(posedge clock) disable iff (!reset_n)
        !power_switch |=> (panel_lights == '0 && call_lights == '0))
        else $error("lamps still lit after power off");

endmodule

// ==== bench/floor_request_tb.sv ====
// Floor request controller testbench
// Car model on the req/ack pair, a reference model of lamps, stack and dispatch,
// directed and random button sequences

module floor_request_tb;

    localparam int STACK_DEPTH = 4;
    localparam int TIMEOUT     = 60;

    logic                   clock;
    logic                   reset_n;
    logic                   power_switch;
    logic                   emergency_btn;
    floor_pkg::floor_mask_t panel_buttons;
    floor_pkg::floor_mask_t floor_call_buttons;
    floor_pkg::floor_t      current_floor;
    logic                   move_ack;
    logic                   move_req;
    floor_pkg::floor_t      target_floor;
    logic                   direction_up;
    floor_pkg::floor_mask_t panel_lights;
    floor_pkg::floor_mask_t call_lights;

    // Reference model state
    floor_pkg::floor_t          model_stack[$];
    floor_pkg::floor_mask_t     exp_panel;
    floor_pkg::floor_mask_t     exp_call;
    floor_pkg::floor_t          exp_target;
    logic                       exp_dir;
    logic                       exp_req;
    floor_pkg::dispatch_state_t model_phase;
    floor_pkg::floor_mask_t     m_lit;
    int                         m_pick;
    bit                         m_from_panel;
    bit                         m_start;
    bit                         m_pop;

    int value_errors   = 0;
    int timeout_errors = 0;

    tb_clock_gen #(.PERIOD(8)) u_clock_gen (.clock(clock));

    floor_request_top #(.STACK_DEPTH(STACK_DEPTH)) dut (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .panel_buttons      (panel_buttons),
        .floor_call_buttons (floor_call_buttons),
        .current_floor      (current_floor),
        .move_ack           (move_ack),
        .move_req           (move_req),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .panel_lights       (panel_lights),
        .call_lights        (call_lights)
    );

    bind floor_request_top floor_request_checker u_checker (
        .clock         (clock),
        .reset_n       (reset_n),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .move_req      (move_req),
        .move_ack      (move_ack),
        .target_floor  (target_floor),
        .panel_lights  (panel_lights),
        .call_lights   (call_lights)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Floor of the press accepted this cycle or -1 when none
    // Panel presses go before calls and lower floors before higher ones
    function automatic int pick_press(input floor_pkg::floor_mask_t panel,
                                      input floor_pkg::floor_mask_t call,
                                      input floor_pkg::floor_mask_t lit,
                                      input floor_pkg::floor_t cur, input bit full,
                                      output bit from_panel);
        int choice;
        choice     = -1;
        from_panel = 1'b0;
        if (!full) begin
            for (int f = 0; f < floor_pkg::NUM_FLOORS && choice < 0; f++) begin
                if (panel[f] && !lit[f] && f != int'(cur)) begin
                    choice     = f;
                    from_panel = 1'b1;
                end
            end
            for (int f = 0; f < floor_pkg::NUM_FLOORS && choice < 0; f++) begin
                if (call[f] && !lit[f] && f != int'(cur)) begin
                    choice = f;
                end
            end
        end
        return choice;
    endfunction

    always @(posedge clock) begin
        if (!reset_n || !power_switch || emergency_btn) begin
            model_stack.delete();
            exp_panel = '0;
            exp_call  = '0;
            if (!reset_n) begin
                model_phase = floor_pkg::IDLE;
                exp_target  = '0;
                exp_dir     = 1'b0;
            end else if (model_phase == floor_pkg::REQUEST) begin
                model_phase = floor_pkg::RELEASE;
            end else if (!move_ack) begin
                model_phase = floor_pkg::IDLE;
            end
        end else begin
            m_lit  = exp_panel | exp_call;
            m_pick = pick_press(panel_buttons, floor_call_buttons, m_lit, current_floor,
                                model_stack.size() >= STACK_DEPTH, m_from_panel);
            m_start = (model_phase == floor_pkg::IDLE) && (model_stack.size() > 0) && !move_ack;
            m_pop   = (model_phase == floor_pkg::REQUEST) && move_ack;
            if (m_start) begin
                exp_target = model_stack[$];
                exp_dir    = (model_stack[$] > current_floor);
            end
            if (m_pop) begin
                exp_panel = exp_panel & ~(floor_pkg::floor_mask_t'(1) << exp_target);
                exp_call  = exp_call & ~(floor_pkg::floor_mask_t'(1) << exp_target);
                if (model_stack.size() > 0) begin
                    void'(model_stack.pop_back());
                end
            end
            if (m_pick >= 0) begin
                model_stack.push_back(floor_pkg::floor_t'(m_pick));
                if (m_from_panel) begin
                    exp_panel = exp_panel | (floor_pkg::floor_mask_t'(1) << m_pick);
                end else begin
                    exp_call = exp_call | (floor_pkg::floor_mask_t'(1) << m_pick);
                end
            end
            if (m_start) begin
                model_phase = floor_pkg::REQUEST;
            end else if (model_phase == floor_pkg::REQUEST && move_ack) begin
                model_phase = floor_pkg::RELEASE;
            end else if (model_phase == floor_pkg::RELEASE && !move_ack) begin
                model_phase = floor_pkg::IDLE;
            end
        end
        exp_req = (model_phase == floor_pkg::REQUEST);
    end

    // Registered outputs are settled by the falling edge
    always @(negedge clock) begin
        if (reset_n) begin
            assert (panel_lights == exp_panel) else begin
                $display("Fail panel_lights: got %h expected %h", panel_lights, exp_panel);
                value_errors++;
            end
            assert (call_lights == exp_call) else begin
                $display("Fail call_lights: got %h expected %h", call_lights, exp_call);
                value_errors++;
            end
            assert (move_req == exp_req) else begin
                $display("Fail move_req: got %h expected %h", move_req, exp_req);
                value_errors++;
            end
            if (exp_req) begin
                assert (target_floor == exp_target) else begin
                    $display("Fail target_floor: got %h expected %h", target_floor, exp_target);
                    value_errors++;
                end
                assert (direction_up == exp_dir) else begin
                    $display("Fail direction_up: got %h expected %h", direction_up, exp_dir);
                    value_errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and car model
    ////////////////////////////////////////////////////////////////////////////

    function automatic floor_pkg::floor_mask_t one_floor(input int f);
        return floor_pkg::floor_mask_t'(1) << f;
    endfunction

    function automatic floor_pkg::floor_mask_t random_mask();
        return floor_pkg::floor_mask_t'($urandom_range(0, 2047) & $urandom_range(0, 2047));
    endfunction

    task automatic wait_for_req(input logic level);
        int cycles;
        cycles = 0;
        while (move_req !== level && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (move_req === level) else begin
            $display("Timeout: move_req did not reach %0b within %0d cycles", level, TIMEOUT);
            timeout_errors++;
        end
    endtask

    task automatic press_hold(input floor_pkg::floor_mask_t p, input floor_pkg::floor_mask_t c,
                              input int cycles);
        panel_buttons      = p;
        floor_call_buttons = c;
        repeat (cycles) @(negedge clock);
        panel_buttons      = '0;
        floor_call_buttons = '0;
    endtask

    // Car answers one dispatch and presses p and c while it still holds move_ack
    task automatic serve_one(input floor_pkg::floor_mask_t p, input floor_pkg::floor_mask_t c,
                             input int hold);
        wait_for_req(1'b1);
        repeat ($urandom_range(1, 5)) @(negedge clock);
        if (move_req) begin
            current_floor = target_floor;
            move_ack      = 1'b1;
            wait_for_req(1'b0);
            press_hold(p, c, hold);
            repeat ($urandom_range(0, 3)) @(negedge clock);
            move_ack = 1'b0;
            @(negedge clock);
        end
    endtask

    task automatic drain_requests();
        int rounds;
        rounds = 0;
        while ((model_stack.size() > 0 || exp_req) && rounds < 16) begin
            serve_one('0, '0, 0);
            rounds++;
        end
    endtask

    initial begin
        void'($urandom(72385));
        reset_n            = 1'b0;
        power_switch       = 1'b1;
        emergency_btn      = 1'b0;
        panel_buttons      = '0;
        floor_call_buttons = '0;
        current_floor      = '0;
        move_ack           = 1'b0;
        repeat (10) @(negedge clock);
        reset_n = 1'b1;
        repeat (2) @(negedge clock);

        // Presses for the current floor or a lit floor change nothing
        press_hold(one_floor(0), one_floor(0), 3);
        press_hold(one_floor(3), '0, 1);
        press_hold(one_floor(3), one_floor(3), 2);

        // Four presses pile up behind the held ack and floor 9 finds the stack full
        serve_one(one_floor(2) | one_floor(5), one_floor(1) | one_floor(7) | one_floor(9), 8);
        drain_requests();

        // Emergency withdraws an open dispatch
        press_hold(one_floor(4) | one_floor(8), '0, 3);
        wait_for_req(1'b1);
        emergency_btn = 1'b1;
        repeat (2) @(negedge clock);
        emergency_btn = 1'b0;
        repeat (12) @(negedge clock);

        // Presses made while the power is off are lost
        press_hold(one_floor(6), one_floor(10), 2);
        wait_for_req(1'b1);
        power_switch = 1'b0;
        press_hold(one_floor(9), '0, 2);
        power_switch = 1'b1;
        repeat (12) @(negedge clock);
        press_hold(one_floor(0), '0, 1);
        drain_requests();

        for (int r = 0; r < 10; r++) begin
            press_hold(random_mask(), random_mask(), $urandom_range(1, 4));
            // A round whose presses were all refused has nothing for the car to serve
            if (model_stack.size() > 0 || exp_req) begin
                serve_one(random_mask(), random_mask(), $urandom_range(0, 4));
            end
            drain_requests();
        end

        repeat (4) @(negedge clock);
        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/floor_pkg.sv
design/button_capture.sv
design/request_stack.sv
design/dispatch_control.sv
design/floor_request_top.sv
bench/tb_clock_gen.sv
bench/floor_request_checker.sv
bench/floor_request_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the floor request controller testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module floor_request_tb -f list.f \
    && ./obj_dir/Vfloor_request_tb > sim.log 2>&1 \
    || echo "Build or simulation stopped early" >> sim.log

cat sim.log

grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
